// ==== Bender.yml ====
package:
  name: stepper_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/stepper_pkg.sv
      - hw/move_if.sv
      - hw/spi_word_rx.sv
      - hw/spi_cmd_decoder.sv
      - hw/move_queue.sv
      - hw/dda_step_gen.sv
      - hw/stepper_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_stepper_ctrl.sv

// ==== dv/tb_stepper_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module tb_stepper_ctrl;

  import stepper_pkg::*;

  localparam int W     = `STEPPER_WORD_BITS;
  localparam int DEPTH = `STEPPER_MOVE_DEPTH;

  logic         CLK           = 1'b0;
  logic         rst           = 1'b1;
  logic         SCK           = 1'b0;
  logic         CS            = 1'b1;
  logic         COPI          = 1'b0;
  logic [W-1:0] encoder_count = '0;
  logic         CIPO;
  logic         step;
  logic         dir;
  logic         enable;
  logic         move_done;
  logic         buffer_ready;
  logic [2:0]   microsteps;
  logic [7:0]   current;
  logic         invert_highside;
  logic         invert_lowside;

  logic [31:0]  lcg_state = 32'd62;
  int unsigned  fail_count = 0;
  // Expected results per queued move, oldest first
  int unsigned  exp_steps[$];
  logic         exp_dir[$];
  int unsigned  step_cnt = 0;
  int unsigned  done_cnt = 0;

  stepper_ctrl_top dut0 (
    .CLK(CLK), .rst(rst), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .encoder_count(encoder_count), .step(step), .dir(dir), .enable(enable),
    .move_done(move_done), .buffer_ready(buffer_ready), .microsteps(microsteps),
    .current(current), .invert_highside(invert_highside),
    .invert_lowside(invert_lowside)
  );

  // 20 ns period
  always #10 CLK = ~CLK;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // Expected step count of one move, wide math so carries stay visible
  function automatic int unsigned ref_steps(input logic [63:0] dur,
                                            input logic signed [63:0] inc0,
                                            input logic signed [63:0] incinc);
    logic signed [127:0] acc_w;
    logic signed [127:0] inc_w;
    logic signed [127:0] total;
    logic signed [127:0] wrap;
    logic signed [63:0]  inc64;
    logic [63:0]         acc64;
    logic [63:0]         t;
    int unsigned         n;
    n     = 0;
    acc64 = '0;
    inc64 = inc0;
    wrap  = 128'sd1 <<< 64;
    for (t = 0; t < dur; t++) begin
      acc_w = {64'd0, acc64};
      inc_w = inc64;
      total = acc_w + inc_w;
      // Overflow past 2^64 for positive, below zero for negative
      if (inc64 >= 0) begin
        if (total >= wrap) n++;
      end else if (total < 0) begin
        n++;
      end
      acc64 = total[63:0];
      inc64 = inc64 + incinc;
    end
    return n;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    if (got !== expected) begin
      fail_count++;
      stop_with_failure($sformatf("FAILED %s: got 0x%h expected 0x%h",
                                  name, got, expected));
    end
  endtask

  // One CS-framed 64-bit transfer, mode 0, SCK half period 4 CLK cycles
  task automatic spi_word(input logic [63:0] tx, output logic [63:0] rx);
    int i;
    @(posedge CLK);
    CS <= 1'b0;
    // Let the DUT see CS fall and load its reply
    repeat (4) @(posedge CLK);
    for (i = W - 1; i >= 0; i--) begin
      COPI <= tx[i];
      repeat (4) @(posedge CLK);
      rx[i] = CIPO;
      SCK <= 1'b1;
      repeat (4) @(posedge CLK);
      SCK <= 1'b0;
    end
    repeat (4) @(posedge CLK);
    CS <= 1'b1;
    // Idle gap covers synchronizer and decoder latency
    repeat (12) @(posedge CLK);
  endtask

  task automatic send_move(input logic d, input logic [63:0] dur,
                           input logic [63:0] inc, input logic [63:0] incinc,
                           output logic [63:0] reply);
    logic [63:0] rx;
    spi_word({CMD_COORDINATED_STEP, 55'd0, d}, rx);
    spi_word(dur, rx);
    spi_word(inc, rx);
    exp_steps.push_back(ref_steps(dur, inc, incinc));
    exp_dir.push_back(d);
    // Encoder snapshot comes back here
    spi_word(incinc, reply);
  endtask

  task automatic wait_moves_done(input int unsigned target, input int limit);
    int n;
    n = 0;
    while (done_cnt < target) begin
      if (n >= limit) begin
        stop_with_failure("Timeout waiting for move_done pulses");
      end
      @(posedge CLK);
      n++;
    end
  endtask

  task automatic wait_buffer_ready(input int limit);
    int n;
    n = 0;
    while (!buffer_ready) begin
      if (n >= limit) begin
        stop_with_failure("Timeout waiting for buffer_ready to rise");
      end
      @(posedge CLK);
      n++;
    end
  endtask

  // Counts steps per move and checks each finished move in order
  always @(posedge CLK) begin
    if (rst) begin
      step_cnt = 0;
    end else begin
      if (step) step_cnt++;
      if (move_done) begin
        if (exp_steps.size() == 0) begin
          stop_with_failure("move_done pulsed with no move outstanding");
        end else begin
          compare_value("step_count", 64'(step_cnt), 64'(exp_steps.pop_front()));
          compare_value("dir", 64'(dir), 64'(exp_dir.pop_front()));
          step_cnt = 0;
          done_cnt++;
        end
      end
    end
  end

  initial begin
    logic [63:0] r;
    logic [63:0] rx;
    logic [63:0] enc;
    logic [63:0] dur;
    logic [63:0] inc;
    logic [63:0] incinc;
    logic        d;
    int          k;
    int          queued;

    repeat (3) @(posedge CLK);
    rst <= 1'b0;
    @(posedge CLK);

    // Defaults after reset
    compare_value("microsteps", 64'(microsteps), 64'd2);
    compare_value("current", 64'(current), 64'd140);
    compare_value("invert_highside", 64'(invert_highside), 64'd0);
    compare_value("invert_lowside", 64'(invert_lowside), 64'd0);
    compare_value("enable", 64'(enable), 64'd0);
    compare_value("buffer_ready", 64'(buffer_ready), 64'd1);

    // Single-word config commands
    for (k = 0; k < 3; k++) begin
      r = rand64();
      spi_word({CMD_MOTOR_ENABLE, r[55:0]}, rx);
      compare_value("enable", 64'(enable), 64'(r[0]));
      r = rand64();
      spi_word({CMD_MOTORCONFIG, r[55:0]}, rx);
      compare_value("current", 64'(current), 64'(r[15:8]));
      compare_value("microsteps", 64'(microsteps), 64'(r[2:0]));
      r = rand64();
      spi_word({CMD_BRIDGEINVERT, r[55:0]}, rx);
      compare_value("invert_highside", 64'(invert_highside), 64'(r[1]));
      compare_value("invert_lowside", 64'(invert_lowside), 64'(r[0]));
    end

    // Faster ticks, one every 4 cycles
    spi_word({CMD_CLK_DIVISOR, 48'd0, 8'd3}, rx);

    // Version query, reply rides on the second word
    spi_word({CMD_API_VERSION, 56'd0}, rx);
    spi_word(64'd0, rx);
    compare_value("version_reply", rx, {40'd0, `STEPPER_VERSION_MAJOR,
                                       `STEPPER_VERSION_MINOR, `STEPPER_VERSION_PATCH});

    // Single moves with encoder snapshot
    for (k = 0; k < 3; k++) begin
      enc = rand64();
      d   = 1'(lcg_next() >> 31);
      dur = 64'(16 + (lcg_next() >> 16) % 48);
      inc = rand64() >> 3;
      incinc = rand64() >> 10;
      @(posedge CLK);
      encoder_count <= enc;
      send_move(d, dur, inc, incinc, rx);
      compare_value("encoder_reply", rx, enc);
      wait_moves_done(done_cnt + 1, 5000);
    end

    // Long move keeps the generator busy while the queue fills
    send_move(1'b1, 64'd5000, 64'h1000_0000_0000_0000, 64'd0, rx);
    queued = 0;
    while (buffer_ready && queued < DEPTH + 2) begin
      d   = 1'(lcg_next() >> 31);
      dur = 64'(8 + 4 * queued);
      inc = rand64() >> 2;
      incinc = rand64() >> 12;
      send_move(d, dur, inc, incinc, rx);
      queued++;
    end
    compare_value("queued_moves", 64'(queued), 64'(DEPTH));
    wait_buffer_ready(30000);
    // Long move plus every queued entry
    wait_moves_done(3 + 1 + DEPTH, 30000);

    if (fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "run ended with failed checks");
    end
  end

endmodule

`default_nettype wire

// ==== hw/dda_step_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module dda_step_gen (
  input  logic               CLK,
  input  logic               rst,
  input  stepper_pkg::move_t head,
  input  logic               not_empty,
  output logic               pop,
  input  logic [7:0]         clock_divisor,
  output logic               step,
  output logic               dir,
  output logic               move_done
);

  import stepper_pkg::*;

  localparam int W = `STEPPER_WORD_BITS;

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

  state_e              state;
  move_t               cur;
  logic [7:0]          presc;
  logic                tick;
  logic [W-1:0]        accum;
  logic signed [W-1:0] inc;
  logic [W-1:0]        tick_cnt;
  // Carry out lands in the top bit
  logic [W:0]          sum;

  assign tick = (state == S_RUN) && (presc == clock_divisor);
  assign sum  = {1'b0, accum} + {1'b0, inc};

  always_ff @(posedge CLK) begin
    if (rst) begin
      state     <= S_IDLE;
      pop       <= 1'b0;
      step      <= 1'b0;
      dir       <= 1'b0;
      move_done <= 1'b0;
      presc     <= 8'd0;
    end else begin
      pop       <= 1'b0;
      step      <= 1'b0;
      move_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (not_empty) begin
            // Take the head now, queue advances next cycle
            pop      <= 1'b1;
            cur      <= head;
            dir      <= head.dir;
            inc      <= head.increment;
            accum    <= '0;
            tick_cnt <= '0;
            presc    <= 8'd0;
            state    <= S_RUN;
          end
        end
        S_RUN: begin
          presc <= tick ? 8'd0 : presc + 8'd1;
          if (tick) begin
            // Carry for positive, borrow for negative increment
            step     <= sum[W] ^ inc[W-1];
            accum    <= sum[W-1:0];
            inc      <= inc + cur.incinc;
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt + 1'b1 >= cur.duration) state <= S_DONE;
          end
        end
        // One cycle after the last step pulse
        default: begin
          move_done <= 1'b1;
          state     <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/move_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

// One move write, decoder to queue
interface move_if;

  logic                                 wr;
  logic                                 dir;
  logic        [`STEPPER_WORD_BITS-1:0] duration;
  logic signed [`STEPPER_WORD_BITS-1:0] increment;
  logic signed [`STEPPER_WORD_BITS-1:0] incinc;
  // Queue has no free slot
  logic                                 full;

  modport producer (output wr, dir, duration, increment, incinc, input full);

  modport consumer (input wr, dir, duration, increment, incinc, output full);

endinterface

`default_nettype wire

// ==== hw/move_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module move_queue (
  input  logic                CLK,
  input  logic                rst,
  move_if.consumer            mv,
  input  logic                pop,
  output stepper_pkg::move_t  head,
  output logic                not_empty
);

  import stepper_pkg::*;

  localparam int DEPTH = `STEPPER_MOVE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  move_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One extra bit to tell full from empty
  logic [PTR_W:0]   count;
  logic             wr_en;
  logic             rd_en;

  assign mv.full   = (count == (PTR_W + 1)'(DEPTH));
  assign not_empty = (count != '0);
  assign wr_en     = mv.wr && !mv.full;
  assign rd_en     = pop && not_empty;
  assign head      = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own width
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(wr_en) - (PTR_W + 1)'(rd_en);
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= move_t'{dir: mv.dir, duration: mv.duration,
                             increment: mv.increment, incinc: mv.incinc};
    end
  end

  // Generator takes a move only when one is waiting
  a_no_pop_when_empty: assert property (@(posedge CLK) disable iff (rst)
    pop |-> not_empty);

endmodule

`default_nettype wire

// ==== hw/spi_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module spi_cmd_decoder (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          word_valid,
  input  logic [`STEPPER_WORD_BITS-1:0] rx_word,
  output logic [`STEPPER_WORD_BITS-1:0] tx_word,
  input  logic [`STEPPER_WORD_BITS-1:0] encoder_count,
  move_if.producer                      mv,
  output logic                          enable,
  output logic [7:0]                    clock_divisor,
  output logic [2:0]                    microsteps,
  output logic [7:0]                    current,
  output logic                          invert_highside,
  output logic                          invert_lowside
);

  import stepper_pkg::*;

  localparam int W = `STEPPER_WORD_BITS;

  // Header of the message in progress
  logic [7:0]          msg_header;
  logic [1:0]          word_cnt;
  logic                busy;
  logic [7:0]          hdr;
  // Encoder value taken at the move header
  logic [W-1:0]        enc_snap;
  logic                wr_q;
  logic                dir_q;
  logic [W-1:0]        dur_q;
  logic signed [W-1:0] inc_q;
  logic signed [W-1:0] incinc_q;

  // Multi-word commands hold the header for later words
  assign busy = (msg_header == CMD_COORDINATED_STEP) || (msg_header == CMD_API_VERSION);
  assign hdr  = rx_word[`STEPPER_HDR_MSB:`STEPPER_HDR_LSB];

  always_ff @(posedge CLK) begin
    if (rst) begin
      msg_header      <= 8'h00;
      word_cnt        <= 2'd0;
      wr_q            <= 1'b0;
      tx_word         <= '0;
      enable          <= 1'b0;
      clock_divisor   <= 8'd40;
      microsteps      <= 3'd2;
      current         <= 8'd140;
      invert_highside <= 1'b0;
      invert_lowside  <= 1'b0;
    end else begin
      wr_q <= 1'b0;
      if (word_valid) begin
        // Reply is zero unless a command sets it
        tx_word <= '0;
        if (!busy) begin
          msg_header <= hdr;
          word_cnt   <= 2'd1;
          case (hdr)
            CMD_COORDINATED_STEP: begin
              dir_q    <= rx_word[0];
              enc_snap <= encoder_count;
            end
            CMD_MOTOR_ENABLE: enable <= rx_word[0];
            CMD_CLK_DIVISOR: clock_divisor <= rx_word[7:0];
            CMD_MOTORCONFIG: begin
              current    <= rx_word[15:8];
              microsteps <= rx_word[2:0];
            end
            CMD_BRIDGEINVERT: begin
              invert_highside <= rx_word[1];
              invert_lowside  <= rx_word[0];
            end
            CMD_API_VERSION: begin
              tx_word[23:0] <= {`STEPPER_VERSION_MAJOR, `STEPPER_VERSION_MINOR,
                                `STEPPER_VERSION_PATCH};
            end
            // Unknown codes do nothing
            default: ;
          endcase
        end else if (msg_header == CMD_COORDINATED_STEP) begin
          word_cnt <= word_cnt + 2'd1;
          case (word_cnt)
            2'd1: dur_q <= rx_word;
            2'd2: begin
              inc_q   <= rx_word;
              // Sent back during the fourth word
              tx_word <= enc_snap;
            end
            default: begin
              incinc_q   <= rx_word;
              wr_q       <= 1'b1;
              word_cnt   <= 2'd0;
              msg_header <= 8'h00;
            end
          endcase
        end else begin
          // Second word of a version query
          msg_header <= 8'h00;
        end
      end
    end
  end

  assign mv.wr        = wr_q;
  assign mv.dir       = dir_q;
  assign mv.duration  = dur_q;
  assign mv.increment = inc_q;
  assign mv.incinc    = incinc_q;

  // Host polls buffer_ready, overrun is lost
  a_no_write_when_full: assert property (@(posedge CLK) disable iff (rst)
    mv.wr |-> !mv.full);

endmodule

`default_nettype wire

// ==== hw/spi_word_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module spi_word_rx (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          SCK,
  input  logic                          CS,
  input  logic                          COPI,
  output logic                          CIPO,
  input  logic [`STEPPER_WORD_BITS-1:0] tx_word,
  output logic                          word_valid,
  output logic [`STEPPER_WORD_BITS-1:0] rx_word
);

  localparam int W     = `STEPPER_WORD_BITS;
  localparam int CNT_W = $clog2(W);

  // Two-flop synchronizers, index 1 is the stable copy
  logic [1:0]       sck_sync;
  logic [1:0]       cs_sync;
  logic [1:0]       copi_sync;
  logic             sck_prev;
  logic             cs_prev;
  logic             sck_rise;
  logic             sck_fall;
  logic             cs_fall;
  logic             cs_rise;
  logic [CNT_W-1:0] bit_cnt;
  logic             last_bit;
  // Top bit never needed, it leaves on the final edge
  logic [W-2:0]     rx_shift;
  logic [W-1:0]     tx_shift;

  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_sync  <= 2'b00;
      cs_sync   <= 2'b11;
      copi_sync <= 2'b00;
      sck_prev  <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[0], SCK};
      cs_sync   <= {cs_sync[0], CS};
      copi_sync <= {copi_sync[0], COPI};
      sck_prev  <= sck_sync[1];
      cs_prev   <= cs_sync[1];
    end
  end

  // Edge detect on synchronized pins
  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign cs_fall  = ~cs_sync[1] & cs_prev;
  assign cs_rise  = cs_sync[1] & ~cs_prev;
  assign last_bit = (bit_cnt == CNT_W'(W - 1));

  // Bit counter, cleared while deselected
  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_sync[1]) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Wraps to zero for the next word
        word_valid <= last_bit;
      end
    end
  end

  // Data paths, MSB first both ways
  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      rx_shift <= {rx_shift[W-3:0], copi_sync[1]};
      if (last_bit) begin
        rx_word <= {rx_shift, copi_sync[1]};
      end
    end
    if (cs_fall) begin
      tx_shift <= tx_word;
    end else if (sck_fall && !cs_sync[1]) begin
      tx_shift <= {tx_shift[W-2:0], 1'b0};
    end
  end

  assign CIPO = tx_shift[W-1];

  // Host must end the frame on a word boundary
  a_cs_whole_word: assert property (@(posedge CLK) disable iff (rst)
    cs_rise |-> (bit_cnt == '0));

endmodule

`default_nettype wire

// ==== hw/stepper_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module stepper_ctrl_top (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          SCK,
  input  logic                          CS,
  input  logic                          COPI,
  output logic                          CIPO,
  input  logic [`STEPPER_WORD_BITS-1:0] encoder_count,
  output logic                          step,
  output logic                          dir,
  output logic                          enable,
  output logic                          move_done,
  output logic                          buffer_ready,
  output logic [2:0]                    microsteps,
  output logic [7:0]                    current,
  output logic                          invert_highside,
  output logic                          invert_lowside
);

  import stepper_pkg::*;

  logic                          word_valid;
  logic [`STEPPER_WORD_BITS-1:0] rx_word;
  logic [`STEPPER_WORD_BITS-1:0] tx_word;
  logic [7:0]                    clock_divisor;
  move_t                         head;
  logic                          not_empty;
  logic                          pop;

  // Decoder to queue
  move_if mv_bus ();

  spi_word_rx u_spi (
    .CLK(CLK), .rst(rst), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .tx_word(tx_word), .word_valid(word_valid), .rx_word(rx_word)
  );

  spi_cmd_decoder u_dec (
    .CLK(CLK), .rst(rst), .word_valid(word_valid), .rx_word(rx_word),
    .tx_word(tx_word), .encoder_count(encoder_count), .mv(mv_bus.producer),
    .enable(enable), .clock_divisor(clock_divisor), .microsteps(microsteps),
    .current(current), .invert_highside(invert_highside),
    .invert_lowside(invert_lowside)
  );

  move_queue u_queue (
    .CLK(CLK), .rst(rst), .mv(mv_bus.consumer), .pop(pop), .head(head),
    .not_empty(not_empty)
  );

  dda_step_gen u_dda (
    .CLK(CLK), .rst(rst), .head(head), .not_empty(not_empty), .pop(pop),
    .clock_divisor(clock_divisor), .step(step), .dir(dir), .move_done(move_done)
  );

  // Host flow control
  assign buffer_ready = ~mv_bus.full;

endmodule

`default_nettype wire

// ==== hw/stepper_macros.svh ====
`ifndef STEPPER_MACROS_SVH
`define STEPPER_MACROS_SVH

// SPI word width, one host transfer
`define STEPPER_WORD_BITS 64

// Move queue slots, must be a power of two
`define STEPPER_MOVE_DEPTH 4

// API version reported to the host
`define STEPPER_VERSION_MAJOR 8'd1
`define STEPPER_VERSION_MINOR 8'd0
`define STEPPER_VERSION_PATCH 8'd2

// Header field position in a word
`define STEPPER_HDR_MSB 63
`define STEPPER_HDR_LSB 56

`endif

// ==== hw/stepper_pkg.sv ====
`default_nettype none

`include "stepper_macros.svh"

package stepper_pkg;

  // Command codes in the header byte
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0A,
    CMD_CLK_DIVISOR      = 8'h0B,
    CMD_MOTORCONFIG      = 8'h10,
    CMD_BRIDGEINVERT     = 8'h12,
    CMD_API_VERSION      = 8'hFE
  } cmd_e;

  // One queued move, 193 bits
  typedef struct packed {
    logic                                 dir;
    // Ticks, unsigned
    logic        [`STEPPER_WORD_BITS-1:0] duration;
    // Added to the accumulator each tick
    logic signed [`STEPPER_WORD_BITS-1:0] increment;
    // Added to increment each tick
    logic signed [`STEPPER_WORD_BITS-1:0] incinc;
  } move_t;

endpackage

`default_nettype wire

// ==== stepper_ctrl.f ====
+incdir+hw
hw/stepper_pkg.sv
hw/move_if.sv
hw/spi_word_rx.sv
hw/spi_cmd_decoder.sv
hw/move_queue.sv
hw/dda_step_gen.sv
hw/stepper_ctrl_top.sv
dv/tb_stepper_ctrl.sv
